//--- mips_pipe.f
+incdir+sim
common/mips_pkg.sv
common/hazard_if.sv
decode/mips_regfile.sv
decode/mips_decode.sv
execute/mips_execute.sv
verilog/mips_hazard.sv
verilog/mips_result.sv
verilog/mips_core.sv
sim/tb_mips_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mips_pipe testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mips_core -f mips_pipe.f -o tb_mips_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_mips_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" <<< "$out"; then
    exit 0
fi
exit 1

//--- sim/tb_mips_model.svh
// mips reference model
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// ********************
// random numbers and encoding

// lcg step, the upper half has the better bits
function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, rng_state[31:16]};
endfunction

function automatic logic [31:0] pick(input logic [31:0] n);
    return next_rand() % n;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sh);
    return {mips_pkg::op_rtype, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [5:0] alu_fn(input logic [31:0] sel);
    case (sel)
        32'd0:   return mips_pkg::fn_addu;
        32'd1:   return mips_pkg::fn_subu;
        32'd2:   return mips_pkg::fn_and;
        32'd3:   return mips_pkg::fn_or;
        default: return mips_pkg::fn_slt;
    endcase
endfunction

// forward only, never past the halt word
function automatic logic [15:0] branch_off(input int p);
    int room;
    room = prog_len - 2 - p;
    return 16'((room < 3) ? room : pick(4));
endfunction

// ********************
// program generator
task automatic build_program();
    int          n;
    logic [31:0] kind;
    logic [4:0]  dst;
    logic [4:0]  a;
    logic [4:0]  b;
    logic [4:0]  last;
    logic [5:0]  op;
    rng_state = 32'ha953;
    halt_word = enc_i(mips_pkg::op_beq, 5'd0, 5'd0, 16'hffff);    // beq $0, $0, -1
    for (n = 0; n < 256; n++)
        prog[n] = '0;
    // start values for all registers, the body then works on $0 to $12
    for (n = 1; n < 32; n++)
        prog[n - 1] = enc_i(mips_pkg::op_addiu, 5'd0, 5'(n), 16'(next_rand()));
    n    = 31;
    last = 5'd1;
    while (n < prog_len - 1) begin
        kind = pick(8);
        dst  = 5'(pick(13));                            // $0 as target too
        b    = 5'(pick(13));
        a    = (pick(2) == 0) ? last : 5'(pick(13));    // keeps chains dependent
        case (kind)
            32'd0, 32'd1: begin
                prog[n] = enc_r(alu_fn(pick(5)), a, b, dst, 5'd0);
                last    = dst;
            end
            32'd2: begin
                op      = (pick(2) == 0) ? mips_pkg::fn_sll : mips_pkg::fn_srl;
                prog[n] = enc_r(op, 5'd0, a, dst, 5'(pick(32)));
                last    = dst;
            end
            32'd3: begin
                kind = pick(3);
                op   = (kind == 0) ? mips_pkg::op_addiu :
                       (kind == 1) ? mips_pkg::op_ori : mips_pkg::op_lui;
                prog[n] = enc_i(op, (op == mips_pkg::op_lui) ? 5'd0 : a, dst,
                                16'(next_rand()));
                last = dst;
            end
            32'd4: begin
                prog[n] = enc_i(mips_pkg::op_lw, a, dst, 16'(pick(256)));
                n++;
                // the loaded value is needed right away
                if (pick(2) == 0)
                    prog[n] = enc_r(mips_pkg::fn_addu, dst, b, a, 5'd0);
                else
                    prog[n] = enc_i(mips_pkg::op_bne, dst, b, branch_off(n));
                last = dst;
            end
            32'd5: prog[n] = enc_i(mips_pkg::op_sw, b, a, 16'(pick(256)));
            default: begin
                op      = (pick(2) == 0) ? mips_pkg::op_beq : mips_pkg::op_bne;
                b       = (pick(2) == 0) ? a : b;       // same register forces the outcome
                prog[n] = enc_i(op, a, b, branch_off(n));
            end
        endcase
        n++;
    end
    prog[prog_len - 1] = halt_word;
endtask

// ********************
// instruction-level reference, returns the halt pc
function automatic logic [31:0] run_reference();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [4:0]  dst;
    int          k;
    int          steps;
    for (k = 0; k < 32; k++)
        ref_regs[k] = '0;
    for (k = 0; k < 256; k++)
        ref_dmem[k] = fill_word(8'(k));
    pc    = '0;
    steps = 0;
    while (prog[pc[7:0]] != halt_word && steps < 4096) begin
        ins  = prog[pc[7:0]];
        a    = ref_regs[ins[25:21]];
        b    = ref_regs[ins[20:16]];
        simm = {{16{ins[15]}}, ins[15:0]};
        addr = a + simm;            // data memory decodes the low 8 bits only
        res  = '0;
        dst  = ins[20:16];
        case (ins[31:26])
            mips_pkg::op_rtype: begin
                dst = ins[15:11];
                case (ins[5:0])
                    mips_pkg::fn_addu: res = a + b;
                    mips_pkg::fn_subu: res = a - b;
                    mips_pkg::fn_and:  res = a & b;
                    mips_pkg::fn_or:   res = a | b;
                    mips_pkg::fn_slt:  res = {31'h0, $signed(a) < $signed(b)};
                    mips_pkg::fn_sll:  res = b << ins[10:6];
                    mips_pkg::fn_srl:  res = b >> ins[10:6];
                    default:           dst = 5'd0;
                endcase
            end
            mips_pkg::op_addiu: res = addr;
            mips_pkg::op_ori:   res = a | {16'h0, ins[15:0]};
            mips_pkg::op_lui:   res = {ins[15:0], 16'h0};
            mips_pkg::op_lw:    res = ref_dmem[addr[7:0]];
            mips_pkg::op_sw: begin
                ref_dmem[addr[7:0]] = b;
                dst = 5'd0;
            end
            default: dst = 5'd0;    // branches and unknown opcodes
        endcase
        if (dst != 5'd0)
            ref_regs[dst] = res;
        // no delay slot
        if ((ins[31:26] == mips_pkg::op_beq && a == b) ||
            (ins[31:26] == mips_pkg::op_bne && a != b))
            pc = pc + 1 + simm;
        else
            pc = pc + 1;
        steps++;
    end
    return pc;
endfunction

`endif

//--- sim/tb_mips_core.sv
// mips pipeline testbench
`timescale 1ns/100ps

module tb_mips_core;

    localparam int prog_len    = 200;
    localparam int clk_period  = 100;
    localparam int rst_cycles  = 16;
    localparam int tail_cycles = 10;
    localparam int pc_samples  = 4;

    logic                clk = 1'b0;
    logic                arst_n;
    mips_pkg::reg_addr_t reg_addr;
    mips_pkg::word_t     reg_data;
    mips_pkg::word_t     im_addr;
    mips_pkg::word_t     im_data;
    mips_pkg::word_t     dm_addr;
    logic                dm_we;
    mips_pkg::word_t     dm_wdata;
    mips_pkg::word_t     dm_rdata;

    logic [31:0] prog [256];
    logic [31:0] dmem [256];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_dmem [256];
    logic [31:0] dut_regs [32];
    logic [31:0] dut_pc [pc_samples];
    logic [31:0] rng_state;
    logic [31:0] halt_word;
    logic [31:0] halt_pc;
    logic        run_done   = 1'b0;
    int          reset_errs = 0;
    int          reg_errs   = 0;
    int          mem_errs   = 0;
    int          pc_errs    = 0;

    // every address bit shows up in the start contents
    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5c, 8'h00 - a};
    endfunction

    `include "tb_mips_model.svh"

    always #(clk_period / 2) clk = ~clk;

    // ********************
    // memories and dut
    assign im_data  = prog[im_addr[7:0]];
    assign dm_rdata = dmem[dm_addr[7:0]];     // same-cycle read

    always @(posedge clk) begin
        if (dm_we) begin
            dmem[dm_addr[7:0]] <= dm_wdata;
        end
    end

    mips_core dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    task automatic check_idle(input string phase);
        assert (im_addr == '0) else begin
            $display("ERROR %s im_addr: expected %h, actual %h", phase, 32'h0, im_addr);
            reset_errs++;
        end
        assert (dm_we == 1'b0) else begin
            $display("ERROR %s dm_we: expected %b, actual %b", phase, 1'b0, dm_we);
            reset_errs++;
        end
    endtask

    // ********************
    // stimulus
    initial begin
        int k;
        arst_n   = 1'b0;
        reg_addr = '0;
        build_program();
        for (k = 0; k < 256; k++)
            dmem[k] = fill_word(8'(k));
        halt_pc = run_reference();
        repeat (rst_cycles) begin
            @(negedge clk);
            check_idle("reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_idle("after_reset");
        while (im_addr != halt_pc)
            @(negedge clk);
        repeat (tail_cycles) @(negedge clk);
        // debug sweep over registers 1 to 31
        for (k = 1; k < 32; k++) begin
            @(posedge clk);
            reg_addr <= 5'(k);
            @(negedge clk);
            dut_regs[k] = reg_data;
        end
        @(posedge clk);
        reg_addr <= '0;                       // address 0 returns the fetch pc
        for (k = 0; k < pc_samples; k++) begin
            @(negedge clk);
            dut_pc[k] = reg_data;
        end
        run_done = 1'b1;
    end

    // ********************
    // comparison against the reference
    initial begin
        int k;
        bit seen;
        wait (run_done);
        for (k = 1; k < 32; k++) begin
            assert (dut_regs[k] === ref_regs[k]) else begin
                $display("ERROR reg_%0d: expected %h, actual %h", k, ref_regs[k], dut_regs[k]);
                reg_errs++;
            end
        end
        for (k = 0; k < 256; k++) begin
            assert (dmem[k] === ref_dmem[k]) else begin
                $display("ERROR dmem_%0d: expected %h, actual %h", k, ref_dmem[k], dmem[k]);
                mem_errs++;
            end
        end
        // the halt loop refetches itself so pc swings between halt and halt + 1
        seen = 1'b0;
        for (k = 0; k < pc_samples; k++) begin
            seen = seen | (dut_pc[k] == halt_pc);
            assert (dut_pc[k] == halt_pc || dut_pc[k] == halt_pc + 1) else begin
                $display("ERROR halt_pc: expected %h, actual %h", halt_pc, dut_pc[k]);
                pc_errs++;
            end
        end
        assert (seen) else begin
            $display("the debug port never showed the halt pc");
            pc_errs++;
        end
        $display("errors: reset %0d, registers %0d, memory %0d, halt pc %0d",
                 reset_errs, reg_errs, mem_errs, pc_errs);
        if (reset_errs + reg_errs + mem_errs + pc_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // budget of four cycles per program word plus reset
    initial begin
        #((4 * prog_len + rst_cycles) * clk_period);
        $display("watchdog expired before the program reached its halt loop");
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- verilog/mips_core.sv
// pipelined mips core
`timescale 1ns/100ps

module mips_core (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::reg_addr_t reg_addr,     // debug register number
    output mips_pkg::word_t     reg_data,
    output mips_pkg::word_t     im_addr,
    input  mips_pkg::word_t     im_data,
    output mips_pkg::word_t     dm_addr,
    output logic                dm_we,
    output mips_pkg::word_t     dm_wdata,
    input  mips_pkg::word_t     dm_rdata
);
    mips_pkg::word_t     pc;
    mips_pkg::word_t     instr_d;
    mips_pkg::word_t     pc_next_d;
    mips_pkg::word_t     branch_target;
    mips_pkg::word_t     debug_data;
    mips_pkg::word_t     alu_result_m;
    mips_pkg::word_t     wb_data;
    mips_pkg::reg_addr_t wb_reg;
    logic                wb_we;
    logic                pc_src;
    mips_pkg::de_stage_t de_q;
    mips_pkg::em_stage_t em_q;

    hazard_if hz0 ();

    // ********************
    // fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (!hz0.stall) begin
            pc <= pc_src ? branch_target : pc + 1;   // word addressed
        end
    end

    assign im_addr = pc;

    // fetch/decode register, a taken branch drops the fetched word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_d   <= '0;
            pc_next_d <= '0;
        end else if (!hz0.stall) begin
            instr_d   <= pc_src ? '0 : im_data;      // all zeros is sll $0 nop
            pc_next_d <= pc + 1;
        end
    end

    assign reg_data = (reg_addr != '0) ? debug_data : pc;

    // ********************
    // stages
    mips_decode decode0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_d       (instr_d),
        .pc_next_d     (pc_next_d),
        .reg_addr      (reg_addr),
        .debug_data    (debug_data),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .wb_we         (wb_we),
        .alu_result_m  (alu_result_m),
        .hz            (hz0),
        .pc_src        (pc_src),
        .branch_target (branch_target),
        .de_q          (de_q)
    );

    mips_execute execute0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .de_q         (de_q),
        .alu_result_m (alu_result_m),
        .wb_data      (wb_data),
        .hz           (hz0),
        .em_q         (em_q)
    );

    mips_result result0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .em_q         (em_q),
        .dm_rdata     (dm_rdata),
        .dm_addr      (dm_addr),
        .dm_we        (dm_we),
        .dm_wdata     (dm_wdata),
        .alu_result_m (alu_result_m),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .wb_we        (wb_we),
        .hz           (hz0)
    );

    mips_hazard hazard0 (
        .hz (hz0)
    );

endmodule

//--- verilog/mips_result.sv
// memory and writeback stages
`timescale 1ns/100ps

module mips_result (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::em_stage_t em_q,
    input  mips_pkg::word_t     dm_rdata,
    output mips_pkg::word_t     dm_addr,
    output logic                dm_we,
    output mips_pkg::word_t     dm_wdata,
    output mips_pkg::word_t     alu_result_m,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data,
    output logic                wb_we,
    hazard_if.result            hz
);
    mips_pkg::word_t alu_result_w;
    mips_pkg::word_t read_data_w;
    logic            reg_write_w;
    logic            mem_to_reg_w;

    // data memory, reads back in the same cycle
    assign dm_addr      = em_q.alu_result;
    assign dm_we        = em_q.mem_write;
    assign dm_wdata     = em_q.store_data;
    assign alu_result_m = em_q.alu_result;

    assign hz.write_reg_m  = em_q.write_reg;
    assign hz.reg_write_m  = em_q.reg_write;
    assign hz.mem_to_reg_m = em_q.mem_to_reg;

    // ********************
    // memory/writeback register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_w  <= em_q.reg_write;
            mem_to_reg_w <= em_q.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= em_q.alu_result;
        read_data_w  <= dm_rdata;
        wb_reg       <= em_q.write_reg;
    end

    assign wb_data = mem_to_reg_w ? read_data_w : alu_result_w;
    assign wb_we   = reg_write_w;

    assign hz.write_reg_w = wb_reg;
    assign hz.reg_write_w = reg_write_w;

endmodule

//--- verilog/mips_hazard.sv
// hazard unit
`timescale 1ns/100ps

module mips_hazard (
    hazard_if.hazard hz
);
    logic load_use;
    logic branch_wait;

    // $zero never counts as a dependence
    function automatic logic hit(mips_pkg::reg_addr_t src, mips_pkg::reg_addr_t dst);
        return (src != '0) && (src == dst);
    endfunction

    // newest value wins so memory goes before writeback
    function automatic mips_pkg::fwd_sel_t fwd_sel(mips_pkg::reg_addr_t src);
        if (hz.reg_write_m && hit(src, hz.write_reg_m)) begin
            return mips_pkg::fwd_mem;
        end else if (hz.reg_write_w && hit(src, hz.write_reg_w)) begin
            return mips_pkg::fwd_wb;
        end
        return mips_pkg::fwd_none;
    endfunction

    // ********************
    // forwarding
    always_comb begin
        hz.fwd_a_e = fwd_sel(hz.rs_e);
        hz.fwd_b_e = fwd_sel(hz.rt_e);
    end

    assign hz.fwd_a_d = hz.reg_write_m & hit(hz.rs_d, hz.write_reg_m);
    assign hz.fwd_b_d = hz.reg_write_m & hit(hz.rt_d, hz.write_reg_m);

    // ********************
    // stalls
    assign load_use = hz.mem_to_reg_e &
                      (hit(hz.rs_d, hz.write_reg_e) | hit(hz.rt_d, hz.write_reg_e));

    // comparator sees memory results only after they leave the alu
    assign branch_wait = hz.branch_d & (
        (hz.reg_write_e & (hit(hz.rs_d, hz.write_reg_e) | hit(hz.rt_d, hz.write_reg_e))) |
        (hz.mem_to_reg_m & (hit(hz.rs_d, hz.write_reg_m) | hit(hz.rt_d, hz.write_reg_m))));

    assign hz.stall = load_use | branch_wait;

endmodule

//--- execute/mips_execute.sv
// execute stage
`timescale 1ns/100ps

module mips_execute (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::de_stage_t de_q,
    input  mips_pkg::word_t     alu_result_m,
    input  mips_pkg::word_t     wb_data,
    hazard_if.execute           hz,
    output mips_pkg::em_stage_t em_q
);
    mips_pkg::word_t     src_a;
    mips_pkg::word_t     src_b;
    mips_pkg::word_t     store_data;     // forwarded rt, also the store data
    mips_pkg::word_t     alu_result;
    mips_pkg::reg_addr_t write_reg;
    mips_pkg::em_stage_t em_d;

    // ********************
    // operand forwarding
    always_comb begin
        case (hz.fwd_a_e)
            mips_pkg::fwd_mem: src_a = alu_result_m;
            mips_pkg::fwd_wb:  src_a = wb_data;
            default:           src_a = de_q.rd1;
        endcase
        case (hz.fwd_b_e)
            mips_pkg::fwd_mem: store_data = alu_result_m;
            mips_pkg::fwd_wb:  store_data = wb_data;
            default:           store_data = de_q.rd2;
        endcase
    end

    assign src_b = de_q.ctrl.alu_src ? de_q.sign_imm : store_data;

    // ********************
    // alu
    always_comb begin
        case (de_q.ctrl.alu_op)
            mips_pkg::alu_add: alu_result = src_a + src_b;
            mips_pkg::alu_sub: alu_result = src_a - src_b;
            mips_pkg::alu_and: alu_result = src_a & src_b;
            mips_pkg::alu_or:  alu_result = src_a | src_b;
            mips_pkg::alu_slt: alu_result = {{(mips_pkg::word_w-1){1'b0}},
                                             $signed(src_a) < $signed(src_b)};
            mips_pkg::alu_sll: alu_result = src_b << de_q.shamt;   // shifts act on rt
            mips_pkg::alu_srl: alu_result = src_b >> de_q.shamt;
            default:           alu_result = src_b << 16;           // lui
        endcase
    end

    assign write_reg = de_q.ctrl.reg_dst ? de_q.rd : de_q.rt;

    assign hz.rs_e         = de_q.rs;
    assign hz.rt_e         = de_q.rt;
    assign hz.write_reg_e  = write_reg;
    assign hz.reg_write_e  = de_q.ctrl.reg_write;
    assign hz.mem_to_reg_e = de_q.ctrl.mem_to_reg;

    always_comb begin
        em_d.reg_write  = de_q.ctrl.reg_write;
        em_d.mem_write  = de_q.ctrl.mem_write;
        em_d.mem_to_reg = de_q.ctrl.mem_to_reg;
        em_d.alu_result = alu_result;
        em_d.store_data = store_data;
        em_d.write_reg  = write_reg;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em_q <= '0;
        end else begin
            em_q <= em_d;
        end
    end

endmodule

//--- decode/mips_decode.sv
// decode stage
`timescale 1ns/100ps

module mips_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::word_t     instr_d,
    input  mips_pkg::word_t     pc_next_d,
    input  mips_pkg::reg_addr_t reg_addr,
    output mips_pkg::word_t     debug_data,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    input  logic                wb_we,
    input  mips_pkg::word_t     alu_result_m,
    hazard_if.decode            hz,
    output logic                pc_src,
    output mips_pkg::word_t     branch_target,
    output mips_pkg::de_stage_t de_q
);
    // instruction fields
    wire [5:0]                      op    = instr_d[31:26];
    wire [5:0]                      fn    = instr_d[5:0];
    wire [mips_pkg::reg_addr_w-1:0] rs    = instr_d[25:21];
    wire [mips_pkg::reg_addr_w-1:0] rt    = instr_d[20:16];
    wire [mips_pkg::reg_addr_w-1:0] rd    = instr_d[15:11];
    wire [mips_pkg::shamt_w-1:0]    shamt = instr_d[10:6];
    wire [15:0]                     imm   = instr_d[15:0];

    mips_pkg::ctrl_t     ctrl;
    mips_pkg::word_t     rd1, rd2;
    mips_pkg::word_t     cmp_a, cmp_b;
    mips_pkg::word_t     sign_imm;
    mips_pkg::de_stage_t de_d;
    logic                is_beq, is_bne;

    // ********************
    // control
    always_comb begin
        ctrl        = '0;        // unknown opcodes fall through as nop
        ctrl.alu_op = mips_pkg::alu_add;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        case (op)
            mips_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (fn)
                    mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
                    default:           ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_pkg::op_ori: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::alu_or;
            end
            mips_pkg::op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_pkg::alu_lui;
            end
            mips_pkg::op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            mips_pkg::op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mips_pkg::op_beq: is_beq = 1'b1;
            mips_pkg::op_bne: is_bne = 1'b1;
            default: ;
        endcase
    end

    mips_regfile regfile0 (
        .clk        (clk),
        .debug_addr (reg_addr),
        .ra1        (rs),
        .ra2        (rt),
        .wa         (wb_reg),
        .wd         (wb_data),
        .we         (wb_we),
        .debug_data (debug_data),
        .rd1        (rd1),
        .rd2        (rd2)
    );

    // ********************
    // early branch resolution
    assign sign_imm      = {{16{imm[15]}}, imm};
    assign branch_target = pc_next_d + sign_imm;     // no delay slot

    assign cmp_a = hz.fwd_a_d ? alu_result_m : rd1;
    assign cmp_b = hz.fwd_b_d ? alu_result_m : rd2;

    assign pc_src = ~hz.stall & ((is_beq & (cmp_a == cmp_b)) | (is_bne & (cmp_a != cmp_b)));

    assign hz.rs_d     = rs;
    assign hz.rt_d     = rt;
    assign hz.branch_d = is_beq | is_bne;

    always_comb begin
        de_d.ctrl     = hz.stall ? '0 : ctrl;     // bubble
        de_d.rd1      = rd1;
        de_d.rd2      = rd2;
        de_d.sign_imm = (op == mips_pkg::op_ori) ? {16'h0, imm} : sign_imm;  // ori zero-extends
        de_d.rs       = rs;
        de_d.rt       = rt;
        de_d.rd       = rd;
        de_d.shamt    = shamt;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_q <= '0;
        end else begin
            de_q <= de_d;
        end
    end

endmodule

//--- decode/mips_regfile.sv
// register file
`timescale 1ns/100ps

module mips_regfile (
    input  logic                clk,
    input  mips_pkg::reg_addr_t debug_addr,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t ra2,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::word_t     wd,
    input  logic                we,
    output mips_pkg::word_t     debug_data,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     rd2
);
    mips_pkg::word_t regs [2**mips_pkg::reg_addr_w];

    // written in the first half of the cycle, so decode
    // reads the new value in the second half
    always_ff @(negedge clk) begin
        if (we) begin
            regs[wa] <= wd;
        end
    end

    // $zero reads as zero whatever was written there
    assign rd1        = (ra1 != '0) ? regs[ra1] : '0;
    assign rd2        = (ra2 != '0) ? regs[ra2] : '0;
    assign debug_data = (debug_addr != '0) ? regs[debug_addr] : '0;

endmodule

//--- common/hazard_if.sv
// hazard unit interface
`timescale 1ns/100ps

interface hazard_if;

    mips_pkg::reg_addr_t rs_d;
    mips_pkg::reg_addr_t rt_d;
    logic                branch_d;

    mips_pkg::reg_addr_t rs_e;
    mips_pkg::reg_addr_t rt_e;
    mips_pkg::reg_addr_t write_reg_e;
    logic                reg_write_e;
    logic                mem_to_reg_e;

    mips_pkg::reg_addr_t write_reg_m;
    logic                reg_write_m;
    logic                mem_to_reg_m;
    mips_pkg::reg_addr_t write_reg_w;
    logic                reg_write_w;

    mips_pkg::fwd_sel_t  fwd_a_e;
    mips_pkg::fwd_sel_t  fwd_b_e;
    logic                fwd_a_d;    // alu result of memory stage into comparator
    logic                fwd_b_d;
    logic                stall;

    modport decode (output rs_d, rt_d, branch_d, input fwd_a_d, fwd_b_d, stall);
    modport execute (output rs_e, rt_e, write_reg_e, reg_write_e, mem_to_reg_e,
                     input fwd_a_e, fwd_b_e);
    modport result (output write_reg_m, reg_write_m, mem_to_reg_m, write_reg_w, reg_write_w);
    modport hazard (input rs_d, rt_d, branch_d, rs_e, rt_e, write_reg_e, reg_write_e,
                    mem_to_reg_e, write_reg_m, reg_write_m, mem_to_reg_m, write_reg_w,
                    reg_write_w, output fwd_a_e, fwd_b_e, fwd_a_d, fwd_b_d, stall);

endinterface

//--- common/mips_pkg.sv
// mips pipeline shared definitions
package mips_pkg;

    // ********************
    // widths and base types
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 3;
    localparam int shamt_w    = 5;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [alu_op_w-1:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_slt, alu_sll, alu_srl, alu_lui
    } alu_op_t;

    // operand source in execute and decode
    typedef enum logic [1:0] {
        fwd_none, fwd_mem, fwd_wb
    } fwd_sel_t;

    // ********************
    // opcodes and function codes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_srl   = 6'h02;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_slt   = 6'h2a;

    // ********************
    // stage payloads
    typedef struct packed {
        logic    reg_write;
        logic    reg_dst;     // 1: rd, 0: rt
        logic    alu_src;     // 1: immediate
        alu_op_t alu_op;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                ctrl;
        word_t                rd1;
        word_t                rd2;
        word_t                sign_imm;
        reg_addr_t            rs;
        reg_addr_t            rt;
        reg_addr_t            rd;
        logic [shamt_w-1:0]   shamt;
    } de_stage_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t write_reg;
    } em_stage_t;

endpackage
